/* hdl/hdc_config.svh */
`ifndef HDC_CONFIG_SVH
`define HDC_CONFIG_SVH

// hypervector geometry
`define HDC_WORD_BITS       32
`define HDC_HV_WORDS        4
`define HDC_HV_BITS         (`HDC_WORD_BITS * `HDC_HV_WORDS)

// item memory depth is 2**HDC_ITEM_ADDR_BITS
`define HDC_ITEM_ADDR_BITS  4

// xorshift32 starting state
`define HDC_PRNG_SEED       32'h2545f491

// stream input word, item address in the low bits
`define HDC_STREAM_IN_BITS  16

// axi-lite register map
`define HDC_LITE_ADDR_BITS  12
`define HDC_REG_MODE        12'h000
`define HDC_REG_ITEM_LAST   12'h004

`endif

/* hdl/hdc_pkg.sv */
`include "hdc_config.svh"

package hdc_pkg;

    // one random word from the generator
    typedef logic [`HDC_WORD_BITS-1:0] word_t;

    // index into the item memory
    typedef logic [`HDC_ITEM_ADDR_BITS-1:0] item_addr_t;

    // word position inside one hypervector
    typedef logic [$clog2(`HDC_HV_WORDS)-1:0] slot_t;

    // one hypervector, built word by word and streamed out whole
    // words[0] sits in the low bits of flat
    typedef union packed {
        logic [`HDC_HV_BITS-1:0]        flat;
        word_t [`HDC_HV_WORDS-1:0]      words;
    } hv_t;

endpackage

/* hdl/hdc_ctrl_regs.sv */
`timescale 1ns/1ns
`include "hdc_config.svh"

module hdc_ctrl_regs (
    input  logic                            AXIS_ACLK,
    input  logic                            S_AXI_ARESETN,

    input  logic [`HDC_LITE_ADDR_BITS-1:0]  s_axi_awaddr,
    input  logic                            s_axi_awvalid,
    output logic                            s_axi_awready,

    input  logic [31:0]                     s_axi_wdata,
    input  logic                            s_axi_wvalid,
    output logic                            s_axi_wready,

    output logic [1:0]                      s_axi_bresp,
    output logic                            s_axi_bvalid,
    input  logic                            s_axi_bready,

    input  logic [`HDC_LITE_ADDR_BITS-1:0]  s_axi_araddr,
    input  logic                            s_axi_arvalid,
    output logic                            s_axi_arready,

    output logic [31:0]                     s_axi_rdata,
    output logic [1:0]                      s_axi_rresp,
    output logic                            s_axi_rvalid,
    input  logic                            s_axi_rready,

    input  logic                            gen_done,
    output logic                            gen,
    output logic                            run,
    output hdc_pkg::item_addr_t             item_last
);
    import hdc_pkg::*;

    // ------------------------------
    // slave state machine
    // ------------------------------

    localparam logic [2:0] st_idle     = 3'd0;
    localparam logic [2:0] st_addr     = 3'd1;
    localparam logic [2:0] st_data     = 3'd2;
    localparam logic [2:0] st_both     = 3'd3;
    localparam logic [2:0] st_rd_wait  = 3'd4;
    localparam logic [2:0] st_rd_valid = 3'd5;

    logic [2:0]                     state;
    logic [`HDC_LITE_ADDR_BITS-1:0] wr_addr;
    logic [31:0]                    wr_data;
    logic [`HDC_LITE_ADDR_BITS-1:0] rd_addr;
    logic [`HDC_LITE_ADDR_BITS-1:0] wr_offset;
    logic [`HDC_LITE_ADDR_BITS-1:0] rd_offset;
    logic                           reg_wr;

    assign s_axi_awready = (state == st_idle) || (state == st_data);
    assign s_axi_wready  = (state == st_idle) || (state == st_addr);
    // a pending write wins over a read in idle
    assign s_axi_arready = (state == st_idle) && !s_axi_awvalid && !s_axi_wvalid;
    assign s_axi_bvalid  = (state == st_both);
    assign s_axi_rvalid  = (state == st_rd_valid);
    assign s_axi_bresp   = 2'b00;
    assign s_axi_rresp   = 2'b00;

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (s_axi_awvalid && s_axi_wvalid) begin
                        state <= st_both;
                    end else if (s_axi_awvalid) begin
                        state <= st_addr;
                    end else if (s_axi_wvalid) begin
                        state <= st_data;
                    end else if (s_axi_arvalid) begin
                        state <= st_rd_wait;
                    end
                end
                st_addr: begin
                    if (s_axi_wvalid) begin
                        state <= st_both;
                    end
                end
                st_data: begin
                    if (s_axi_awvalid) begin
                        state <= st_both;
                    end
                end
                st_both: begin
                    if (s_axi_bready) begin
                        state <= st_idle;
                    end
                end
                st_rd_wait: begin
                    state <= st_rd_valid;
                end
                st_rd_valid: begin
                    if (s_axi_rready) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // address and data capture, either order
    always_ff @(posedge AXIS_ACLK) begin
        if (s_axi_awvalid && s_axi_awready) begin
            wr_addr <= s_axi_awaddr;
        end
        if (s_axi_wvalid && s_axi_wready) begin
            wr_data <= s_axi_wdata;
        end
        if (s_axi_arvalid && s_axi_arready) begin
            rd_addr <= s_axi_araddr;
        end
    end

    // ------------------------------
    // register file
    // ------------------------------

    // word aligned offsets
    assign wr_offset = {wr_addr[`HDC_LITE_ADDR_BITS-1:2], 2'b00};
    assign rd_offset = {rd_addr[`HDC_LITE_ADDR_BITS-1:2], 2'b00};
    assign reg_wr    = (state == st_both);

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            gen       <= 1'b0;
            run       <= 1'b0;
            item_last <= '0;
        end else if (reg_wr) begin
            case (wr_offset)
                `HDC_REG_MODE: begin
                    {run, gen} <= wr_data[1:0];
                end
                `HDC_REG_ITEM_LAST: begin
                    item_last <= item_addr_t'(wr_data[`HDC_ITEM_ADDR_BITS-1:0]);
                end
                default: begin
                end
            endcase
        end else if (gen_done) begin
            // last item written, generation over
            gen <= 1'b0;
        end
    end

    // read data settles in the wait state
    always_ff @(posedge AXIS_ACLK) begin
        if (state == st_rd_wait) begin
            case (rd_offset)
                `HDC_REG_MODE: begin
                    s_axi_rdata <= {30'd0, run, gen};
                end
                `HDC_REG_ITEM_LAST: begin
                    s_axi_rdata <= {{(32 - `HDC_ITEM_ADDR_BITS){1'b0}}, item_last};
                end
                default: begin
                    s_axi_rdata <= '0;
                end
            endcase
        end
    end

endmodule

/* hdl/hv_generator.sv */
`timescale 1ns/1ns
`include "hdc_config.svh"

module hv_generator (
    input  logic                AXIS_ACLK,
    input  logic                S_AXI_ARESETN,
    input  logic                gen,
    input  hdc_pkg::item_addr_t item_last,
    output logic                item_wr,
    output hdc_pkg::item_addr_t item_wr_addr,
    output hdc_pkg::hv_t        item_wr_data,
    output logic                gen_done
);
    import hdc_pkg::*;

    localparam slot_t last_slot = slot_t'(`HDC_HV_WORDS - 1);

    word_t      prng_state;
    word_t      prng_next;
    slot_t      slot;
    item_addr_t item_addr;
    hv_t        hv_q;
    hv_t        hv_next;

    // one xorshift32 step, shifts 13 / 17 / 5
    function automatic word_t xorshift32(input word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    assign prng_next = xorshift32(prng_state);

    // ------------------------------
    // sequencing
    // ------------------------------

    // gen low parks everything at the seed
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !gen) begin
            prng_state <= `HDC_PRNG_SEED;
            slot       <= '0;
            item_addr  <= '0;
        end else begin
            prng_state <= prng_next;
            slot       <= slot + 1'b1;
            if (slot == last_slot) begin
                item_addr <= item_addr + 1'b1;
            end
        end
    end

    // ------------------------------
    // hypervector assembly
    // ------------------------------

    // current word dropped into its slot
    always_comb begin
        hv_next             = hv_q;
        hv_next.words[slot] = prng_state;
    end

    always_ff @(posedge AXIS_ACLK) begin
        if (gen) begin
            hv_q <= hv_next;
        end
    end

    // write goes out on the cycle that fills the last slot
    assign item_wr      = gen && (slot == last_slot);
    assign item_wr_addr = item_addr;
    assign item_wr_data = hv_next;
    assign gen_done     = item_wr && (item_addr == item_last);

endmodule

/* hdl/item_memory.sv */
`timescale 1ns/1ns
`include "hdc_config.svh"

module item_memory (
    input  logic                            AXIS_ACLK,
    input  logic                            S_AXI_ARESETN,
    input  logic                            run,

    input  logic                            item_wr,
    input  hdc_pkg::item_addr_t             item_wr_addr,
    input  hdc_pkg::hv_t                    item_wr_data,

    input  logic [`HDC_STREAM_IN_BITS-1:0]  s_axis_tdata,
    input  logic                            s_axis_tvalid,
    input  logic                            s_axis_tlast,
    output logic                            s_axis_tready,

    output logic [`HDC_HV_BITS-1:0]         m_axis_tdata,
    output logic                            m_axis_tvalid,
    output logic                            m_axis_tlast
);
    import hdc_pkg::*;

    localparam int items = 1 << `HDC_ITEM_ADDR_BITS;

    hv_t        mem [items];
    logic       lookup;
    item_addr_t rd_addr_q;
    logic       rd_vld_q;
    logic       rd_last_q;
    hv_t        rd_data_q;

    // no back-pressure, ready just mirrors run mode
    assign s_axis_tready = run;
    assign lookup        = s_axis_tvalid && run;

    always_ff @(posedge AXIS_ACLK) begin
        if (item_wr) begin
            mem[item_wr_addr] <= item_wr_data;
        end
    end

    // ------------------------------
    // lookup pipeline
    // ------------------------------

    // stage 1, address and last
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            rd_vld_q <= 1'b0;
        end else begin
            rd_vld_q <= lookup;
        end
    end

    always_ff @(posedge AXIS_ACLK) begin
        if (lookup) begin
            rd_addr_q <= s_axis_tdata[`HDC_ITEM_ADDR_BITS-1:0];
            rd_last_q <= s_axis_tlast;
        end
    end

    // stage 2, array read
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            m_axis_tvalid <= 1'b0;
        end else begin
            m_axis_tvalid <= rd_vld_q;
        end
    end

    // a write on the same edge is seen by the read
    always_ff @(posedge AXIS_ACLK) begin
        if (item_wr && (item_wr_addr == rd_addr_q)) begin
            rd_data_q <= item_wr_data;
        end else begin
            rd_data_q <= mem[rd_addr_q];
        end
        m_axis_tlast <= rd_last_q;
    end

    assign m_axis_tdata = rd_data_q.flat;

endmodule

/* hdl/hdc_top.sv */
`timescale 1ns/1ns
`include "hdc_config.svh"

module hdc_top (
    input  logic                            AXIS_ACLK,
    input  logic                            S_AXI_ARESETN,

    // axi-lite slave
    input  logic [`HDC_LITE_ADDR_BITS-1:0]  s_axi_awaddr,
    input  logic                            s_axi_awvalid,
    output logic                            s_axi_awready,
    input  logic [31:0]                     s_axi_wdata,
    input  logic                            s_axi_wvalid,
    output logic                            s_axi_wready,
    output logic [1:0]                      s_axi_bresp,
    output logic                            s_axi_bvalid,
    input  logic                            s_axi_bready,
    input  logic [`HDC_LITE_ADDR_BITS-1:0]  s_axi_araddr,
    input  logic                            s_axi_arvalid,
    output logic                            s_axi_arready,
    output logic [31:0]                     s_axi_rdata,
    output logic [1:0]                      s_axi_rresp,
    output logic                            s_axi_rvalid,
    input  logic                            s_axi_rready,

    // lookup stream in
    input  logic [`HDC_STREAM_IN_BITS-1:0]  s_axis_tdata,
    input  logic                            s_axis_tvalid,
    input  logic                            s_axis_tlast,
    output logic                            s_axis_tready,

    // hypervector stream out
    output logic [`HDC_HV_BITS-1:0]         m_axis_tdata,
    output logic                            m_axis_tvalid,
    output logic                            m_axis_tlast
);
    import hdc_pkg::*;

    logic       gen;
    logic       run;
    item_addr_t item_last;
    logic       gen_done;
    logic       item_wr;
    item_addr_t item_wr_addr;
    hv_t        item_wr_data;

    hdc_ctrl_regs u_ctrl_regs (
        .AXIS_ACLK      (AXIS_ACLK),
        .S_AXI_ARESETN  (S_AXI_ARESETN),
        .s_axi_awaddr   (s_axi_awaddr),
        .s_axi_awvalid  (s_axi_awvalid),
        .s_axi_awready  (s_axi_awready),
        .s_axi_wdata    (s_axi_wdata),
        .s_axi_wvalid   (s_axi_wvalid),
        .s_axi_wready   (s_axi_wready),
        .s_axi_bresp    (s_axi_bresp),
        .s_axi_bvalid   (s_axi_bvalid),
        .s_axi_bready   (s_axi_bready),
        .s_axi_araddr   (s_axi_araddr),
        .s_axi_arvalid  (s_axi_arvalid),
        .s_axi_arready  (s_axi_arready),
        .s_axi_rdata    (s_axi_rdata),
        .s_axi_rresp    (s_axi_rresp),
        .s_axi_rvalid   (s_axi_rvalid),
        .s_axi_rready   (s_axi_rready),
        .gen_done       (gen_done),
        .gen            (gen),
        .run            (run),
        .item_last      (item_last)
    );

    hv_generator u_hv_generator (
        .AXIS_ACLK      (AXIS_ACLK),
        .S_AXI_ARESETN  (S_AXI_ARESETN),
        .gen            (gen),
        .item_last      (item_last),
        .item_wr        (item_wr),
        .item_wr_addr   (item_wr_addr),
        .item_wr_data   (item_wr_data),
        .gen_done       (gen_done)
    );

    item_memory u_item_memory (
        .AXIS_ACLK      (AXIS_ACLK),
        .S_AXI_ARESETN  (S_AXI_ARESETN),
        .run            (run),
        .item_wr        (item_wr),
        .item_wr_addr   (item_wr_addr),
        .item_wr_data   (item_wr_data),
        .s_axis_tdata   (s_axis_tdata),
        .s_axis_tvalid  (s_axis_tvalid),
        .s_axis_tlast   (s_axis_tlast),
        .s_axis_tready  (s_axis_tready),
        .m_axis_tdata   (m_axis_tdata),
        .m_axis_tvalid  (m_axis_tvalid),
        .m_axis_tlast   (m_axis_tlast)
    );

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int half_period  = 5,
    parameter int reset_cycles = 10
) (
    output logic AXIS_ACLK,
    output logic S_AXI_ARESETN
);

    initial begin
        AXIS_ACLK = 1'b0;
        forever #half_period AXIS_ACLK = ~AXIS_ACLK;
    end

    // synchronous reset, released just after an edge
    initial begin
        S_AXI_ARESETN = 1'b0;
        repeat (reset_cycles) @(posedge AXIS_ACLK);
        #1;
        S_AXI_ARESETN = 1'b1;
    end

endmodule

/* verif/tb_hdc_top.sv */
`timescale 1ns/1ns
`include "hdc_config.svh"

module tb_hdc_top;

    localparam int timeout_cycles = 200;
    localparam int poll_limit     = 50;
    localparam int lookup_latency = 2;
    localparam int max_steps      = 32;

    typedef enum logic [2:0] {
        wr_addr_first,
        wr_data_first,
        rd_check,
        poll_gen,
        lookup_shuffled,
        lookup_burst,
        lookup_gated
    } step_kind_t;

    // burst and gated steps keep the lookup count in addr
    // item indices sit as nibbles in data and tlast bits in expected
    typedef struct {
        int                             test;
        step_kind_t                     kind;
        logic [`HDC_LITE_ADDR_BITS-1:0] addr;
        logic [31:0]                    data;
        logic [31:0]                    expected;
    } step_t;

    logic                            AXIS_ACLK;
    logic                            S_AXI_ARESETN;
    logic [`HDC_LITE_ADDR_BITS-1:0]  s_axi_awaddr;
    logic                            s_axi_awvalid;
    logic                            s_axi_awready;
    logic [31:0]                     s_axi_wdata;
    logic                            s_axi_wvalid;
    logic                            s_axi_wready;
    logic [1:0]                      s_axi_bresp;
    logic                            s_axi_bvalid;
    logic                            s_axi_bready;
    logic [`HDC_LITE_ADDR_BITS-1:0]  s_axi_araddr;
    logic                            s_axi_arvalid;
    logic                            s_axi_arready;
    logic [31:0]                     s_axi_rdata;
    logic [1:0]                      s_axi_rresp;
    logic                            s_axi_rvalid;
    logic                            s_axi_rready;
    logic [`HDC_STREAM_IN_BITS-1:0]  s_axis_tdata;
    logic                            s_axis_tvalid;
    logic                            s_axis_tlast;
    logic                            s_axis_tready;
    logic [`HDC_HV_BITS-1:0]         m_axis_tdata;
    logic                            m_axis_tvalid;
    logic                            m_axis_tlast;

    step_t                   steps [max_steps];
    int                      num_steps;
    string                   test_names [1:6];
    logic [3:0]              burst_items [$];
    logic                    burst_lasts [$];
    logic [`HDC_HV_BITS-1:0] seen [16];
    logic                    seen_valid [16];
    int                      errors;
    int                      test_errors;
    int                      tests_run;
    int                      tests_failed;

    tb_clock_gen clock_gen (
        .AXIS_ACLK      (AXIS_ACLK),
        .S_AXI_ARESETN  (S_AXI_ARESETN)
    );

    hdc_top dut (
        .AXIS_ACLK      (AXIS_ACLK),
        .S_AXI_ARESETN  (S_AXI_ARESETN),
        .s_axi_awaddr   (s_axi_awaddr),
        .s_axi_awvalid  (s_axi_awvalid),
        .s_axi_awready  (s_axi_awready),
        .s_axi_wdata    (s_axi_wdata),
        .s_axi_wvalid   (s_axi_wvalid),
        .s_axi_wready   (s_axi_wready),
        .s_axi_bresp    (s_axi_bresp),
        .s_axi_bvalid   (s_axi_bvalid),
        .s_axi_bready   (s_axi_bready),
        .s_axi_araddr   (s_axi_araddr),
        .s_axi_arvalid  (s_axi_arvalid),
        .s_axi_arready  (s_axi_arready),
        .s_axi_rdata    (s_axi_rdata),
        .s_axi_rresp    (s_axi_rresp),
        .s_axi_rvalid   (s_axi_rvalid),
        .s_axi_rready   (s_axi_rready),
        .s_axis_tdata   (s_axis_tdata),
        .s_axis_tvalid  (s_axis_tvalid),
        .s_axis_tlast   (s_axis_tlast),
        .s_axis_tready  (s_axis_tready),
        .m_axis_tdata   (m_axis_tdata),
        .m_axis_tvalid  (m_axis_tvalid),
        .m_axis_tlast   (m_axis_tlast)
    );

    // ------------------------------
    // reference model
    // ------------------------------

    function automatic logic [31:0] xorshift_step(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // word k of item n is the seed advanced n*4+k times with word 0 lowest
    function automatic logic [`HDC_HV_BITS-1:0] expected_item(input int item);
        logic [31:0]             state;
        logic [`HDC_HV_BITS-1:0] hv;
        int                      k;
        state = `HDC_PRNG_SEED;
        for (k = 0; k < item * `HDC_HV_WORDS; k++) begin
            state = xorshift_step(state);
        end
        for (k = 0; k < `HDC_HV_WORDS; k++) begin
            hv[k*`HDC_WORD_BITS +: `HDC_WORD_BITS] = state;
            state = xorshift_step(state);
        end
        return hv;
    endfunction

    // ------------------------------
    // reporting and bus tasks
    // ------------------------------

    task automatic tick();
        @(posedge AXIS_ACLK);
        #1;
    endtask

    task automatic report_mismatch(input string name, input logic [127:0] got,
                                   input logic [127:0] exp);
        errors++;
        test_errors++;
        $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
    endtask

    task automatic report_problem(input string msg);
        errors++;
        test_errors++;
        $display("%s", msg);
    endtask

    task automatic finish_test(input int test);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d %s: ok", test, test_names[test]);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", test, test_names[test], test_errors);
        end
        test_errors = 0;
    endtask

    task automatic send_addr(input logic [`HDC_LITE_ADDR_BITS-1:0] addr);
        int n;
        s_axi_awaddr  = addr;
        s_axi_awvalid = 1'b1;
        n = 0;
        while (s_axi_awready !== 1'b1 && n < timeout_cycles) begin
            tick();
            n++;
        end
        if (s_axi_awready !== 1'b1) begin
            report_problem("timeout waiting for s_axi_awready");
        end
        tick();
        s_axi_awvalid = 1'b0;
    endtask

    task automatic send_data(input logic [31:0] data);
        int n;
        s_axi_wdata  = data;
        s_axi_wvalid = 1'b1;
        n = 0;
        while (s_axi_wready !== 1'b1 && n < timeout_cycles) begin
            tick();
            n++;
        end
        if (s_axi_wready !== 1'b1) begin
            report_problem("timeout waiting for s_axi_wready");
        end
        tick();
        s_axi_wvalid = 1'b0;
    endtask

    task automatic await_bresp();
        int n;
        n = 0;
        while (s_axi_bvalid !== 1'b1 && n < timeout_cycles) begin
            tick();
            n++;
        end
        if (s_axi_bvalid !== 1'b1) begin
            report_problem("no write response came on s_axi_bvalid");
        end else if (s_axi_bresp !== 2'b00) begin
            report_mismatch("s_axi_bresp", s_axi_bresp, 0);
        end
        s_axi_bready = 1'b1;
        tick();
        s_axi_bready = 1'b0;
    endtask

    task automatic lite_write(input logic [`HDC_LITE_ADDR_BITS-1:0] addr,
                              input logic [31:0] data, input logic data_first);
        if (data_first) begin
            send_data(data);
            send_addr(addr);
        end else begin
            send_addr(addr);
            send_data(data);
        end
        await_bresp();
    endtask

    task automatic lite_read(input logic [`HDC_LITE_ADDR_BITS-1:0] addr,
                             output logic [31:0] data);
        int n;
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        n = 0;
        while (s_axi_arready !== 1'b1 && n < timeout_cycles) begin
            tick();
            n++;
        end
        if (s_axi_arready !== 1'b1) begin
            report_problem("timeout waiting for s_axi_arready");
        end
        tick();
        s_axi_arvalid = 1'b0;
        n = 0;
        while (s_axi_rvalid !== 1'b1 && n < timeout_cycles) begin
            tick();
            n++;
        end
        if (s_axi_rvalid !== 1'b1) begin
            report_problem("no read data came on s_axi_rvalid");
        end else if (s_axi_rresp !== 2'b00) begin
            report_mismatch("s_axi_rresp", s_axi_rresp, 0);
        end
        data = s_axi_rdata;
        s_axi_rready = 1'b1;
        tick();
        s_axi_rready = 1'b0;
    endtask

    // one lookup per cycle
    // output of lookup k is due lookup_latency ticks after its drive
    task automatic run_lookups(input logic accepted);
        int                      n;
        int                      idx;
        int                      total;
        logic [31:0]             rand_bits;
        logic [`HDC_HV_BITS-1:0] exp_hv;
        total = burst_items.size();
        for (n = 0; n < total + lookup_latency + 2; n++) begin
            idx = n - lookup_latency;
            if (s_axis_tready !== accepted) begin
                report_mismatch("s_axis_tready", s_axis_tready, accepted);
            end
            if (accepted && idx >= 0 && idx < total) begin
                exp_hv = expected_item(int'(burst_items[idx]));
                if (m_axis_tvalid !== 1'b1) begin
                    report_mismatch("m_axis_tvalid", m_axis_tvalid, 1);
                end else begin
                    if (m_axis_tdata !== exp_hv) begin
                        report_mismatch("m_axis_tdata", m_axis_tdata, exp_hv);
                    end
                    if (m_axis_tlast !== burst_lasts[idx]) begin
                        report_mismatch("m_axis_tlast", m_axis_tlast, burst_lasts[idx]);
                    end
                    if (seen_valid[burst_items[idx]] &&
                        m_axis_tdata !== seen[burst_items[idx]]) begin
                        report_problem($sformatf("item %0d differs from its earlier value",
                                                 burst_items[idx]));
                    end
                    seen[burst_items[idx]]       = m_axis_tdata;
                    seen_valid[burst_items[idx]] = 1'b1;
                end
            end else if (m_axis_tvalid !== 1'b0) begin
                report_mismatch("m_axis_tvalid", m_axis_tvalid, 0);
            end
            if (n < total) begin
                // upper bits are noise as only the low nibble addresses
                rand_bits     = $urandom;
                s_axis_tdata  = {rand_bits[15:4], burst_items[n]};
                s_axis_tlast  = burst_lasts[n];
                s_axis_tvalid = 1'b1;
            end else begin
                s_axis_tdata  = '0;
                s_axis_tlast  = 1'b0;
                s_axis_tvalid = 1'b0;
            end
            tick();
        end
    endtask

    // ------------------------------
    // step table
    // ------------------------------

    task automatic add_step(input int test, input step_kind_t kind,
                            input logic [`HDC_LITE_ADDR_BITS-1:0] addr,
                            input logic [31:0] data, input logic [31:0] expected);
        steps[num_steps] = '{test, kind, addr, data, expected};
        num_steps++;
    endtask

    task automatic load_steps();
        num_steps = 0;
        add_step(1, rd_check, `HDC_REG_MODE, 0, 0);
        add_step(1, rd_check, `HDC_REG_ITEM_LAST, 0, 0);
        add_step(1, lookup_gated, 0, 0, 0);
        add_step(2, wr_addr_first, `HDC_REG_ITEM_LAST, 32'h5, 0);
        add_step(2, rd_check, `HDC_REG_ITEM_LAST, 0, 32'h5);
        add_step(2, wr_data_first, `HDC_REG_MODE, 32'h2, 0);
        add_step(2, rd_check, `HDC_REG_MODE, 0, 32'h2);
        add_step(2, rd_check, 12'h010, 0, 0);
        add_step(2, wr_data_first, `HDC_REG_MODE, 32'h0, 0);
        add_step(3, wr_data_first, `HDC_REG_MODE, 32'h1, 0);
        add_step(3, poll_gen, `HDC_REG_MODE, 0, 0);
        add_step(3, wr_addr_first, `HDC_REG_MODE, 32'h2, 0);
        add_step(3, rd_check, `HDC_REG_MODE, 0, 32'h2);
        add_step(3, lookup_shuffled, 5, 0, 0);
        add_step(4, lookup_burst, 6, 32'h0041_5203, 32'h24);
        add_step(4, lookup_burst, 4, 32'h0000_1010, 32'h5);
        add_step(5, wr_addr_first, `HDC_REG_MODE, 32'h0, 0);
        add_step(5, rd_check, `HDC_REG_MODE, 0, 0);
        add_step(5, lookup_gated, 4, 32'h0000_3210, 32'hf);
        add_step(6, wr_addr_first, `HDC_REG_ITEM_LAST, 32'h9, 0);
        add_step(6, wr_data_first, `HDC_REG_MODE, 32'h1, 0);
        add_step(6, poll_gen, `HDC_REG_MODE, 0, 0);
        add_step(6, wr_data_first, `HDC_REG_MODE, 32'h2, 0);
        add_step(6, rd_check, `HDC_REG_ITEM_LAST, 0, 32'h9);
        add_step(6, lookup_shuffled, 9, 0, 0);
    endtask

    task automatic apply_step(input step_t st);
        logic [31:0] rdata;
        logic [3:0]  tmp;
        int          k;
        int          j;
        int          n;
        burst_items.delete();
        burst_lasts.delete();
        case (st.kind)
            wr_addr_first: lite_write(st.addr, st.data, 1'b0);
            wr_data_first: lite_write(st.addr, st.data, 1'b1);
            rd_check: begin
                lite_read(st.addr, rdata);
                if (rdata !== st.expected) begin
                    report_mismatch("s_axi_rdata", rdata, st.expected);
                end
            end
            poll_gen: begin
                lite_read(st.addr, rdata);
                n = 0;
                while (rdata[0] !== 1'b0 && n < poll_limit) begin
                    lite_read(st.addr, rdata);
                    n++;
                end
                if (rdata[0] !== 1'b0) begin
                    report_problem("gen was still set after the poll limit");
                end else if (rdata !== st.expected) begin
                    report_mismatch("s_axi_rdata", rdata, st.expected);
                end
            end
            lookup_shuffled: begin
                for (k = 0; k <= int'(st.addr); k++) begin
                    burst_items.push_back(4'(k));
                    burst_lasts.push_back(k == int'(st.addr));
                end
                // shuffle the item order in place
                for (k = int'(st.addr); k > 0; k--) begin
                    j              = int'($urandom % (k + 1));
                    tmp            = burst_items[k];
                    burst_items[k] = burst_items[j];
                    burst_items[j] = tmp;
                end
                run_lookups(1'b1);
            end
            default: begin
                for (k = 0; k < int'(st.addr); k++) begin
                    burst_items.push_back(st.data[4*k +: 4]);
                    burst_lasts.push_back(st.expected[k]);
                end
                run_lookups(st.kind == lookup_burst);
            end
        endcase
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------

    initial begin
        int s;
        int n;
        int prev_test;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        s_axis_tdata  = '0;
        s_axis_tvalid = 1'b0;
        s_axis_tlast  = 1'b0;
        errors        = 0;
        test_errors   = 0;
        tests_run     = 0;
        tests_failed  = 0;
        for (n = 0; n < 16; n++) begin
            seen_valid[n] = 1'b0;
        end
        test_names[1] = "after reset";
        test_names[2] = "register access";
        test_names[3] = "generation";
        test_names[4] = "stream timing";
        test_names[5] = "run gating";
        test_names[6] = "regeneration";
        void'($urandom(32'h6fce4717));
        load_steps();

        n = 0;
        while (S_AXI_ARESETN !== 1'b1 && n < timeout_cycles) begin
            tick();
            n++;
        end
        if (S_AXI_ARESETN !== 1'b1) begin
            report_problem("reset was never released");
        end
        tick();

        prev_test = steps[0].test;
        for (s = 0; s < num_steps; s++) begin
            if (steps[s].test != prev_test) begin
                finish_test(prev_test);
                prev_test = steps[s].test;
            end
            apply_step(steps[s]);
        end
        finish_test(prev_test);

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+hdl
hdl/hdc_pkg.sv
hdl/hdc_ctrl_regs.sv
hdl/hv_generator.sv
hdl/item_memory.sv
hdl/hdc_top.sv
verif/tb_clock_gen.sv
verif/tb_hdc_top.sv

/* Makefile */
# Verilator build and run for the item-memory testbench

VERILATOR ?= verilator
TOP       ?= tb_hdc_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SOURCES := $(wildcard hdl/*.sv hdl/*.svh verif/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	@$(SIM_BIN) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
